// ==== common/axi_merge_pkg.sv ====
`default_nettype none

package axi_merge_pkg;

   // port count and bus widths
   localparam int N_PORTS    = 2;
   localparam int SUB_ADDR_W = 28;
   // port index sits above the subordinate address
   localparam int MGR_ADDR_W = SUB_ADDR_W + $clog2(N_PORTS);
   localparam int DATA_W     = 32;
   localparam int STRB_W     = DATA_W / 8;
   localparam int ID_W       = 4;
   localparam int LEN_W      = 8;
   localparam int SIZE_W     = 3;
   localparam int BURST_W    = 2;
   localparam int RESP_W     = 2;
   // outstanding write counters, full at all ones
   localparam int CNT_W      = 5;

   typedef logic [$clog2(N_PORTS)-1:0] port_idx_t;

   // AR / AW payload as seen by a subordinate port
   typedef struct packed {
      logic [SUB_ADDR_W-1:0] addr;
      logic [ID_W-1:0]       id;
      logic [LEN_W-1:0]      len;
      logic [SIZE_W-1:0]     size;
      logic [BURST_W-1:0]    burst;
   } sub_addr_req_t;

   // same payload on the manager side
   typedef struct packed {
      logic [MGR_ADDR_W-1:0] addr;
      logic [ID_W-1:0]       id;
      logic [LEN_W-1:0]      len;
      logic [SIZE_W-1:0]     size;
      logic [BURST_W-1:0]    burst;
   } mgr_addr_req_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } w_beat_t;

   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [RESP_W-1:0] resp;
      logic [ID_W-1:0]   id;
      logic              last;
   } r_beat_t;

   typedef struct packed {
      logic [RESP_W-1:0] resp;
      logic [ID_W-1:0]   id;
   } b_resp_t;

   // read arbitration
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_ADDR,
      RD_DATA
   } rd_state_e;

   // widen a subordinate request, port index goes on top of the address
   function automatic mgr_addr_req_t to_mgr_req(input port_idx_t port,
                                                input sub_addr_req_t req);
      mgr_addr_req_t res;
      res.addr  = {port, req.addr};
      res.id    = req.id;
      res.len   = req.len;
      res.size  = req.size;
      res.burst = req.burst;
      return res;
   endfunction

endpackage

`default_nettype wire

// ==== merge/txn_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module txn_counter
   import axi_merge_pkg::*;
(
   input  logic clk_i,
   input  logic arst_n_i,
   // one item opened
   input  logic inc_i,
   // one item closed
   input  logic dec_i,
   output logic empty_o,
   output logic full_o
);

   logic [CNT_W-1:0] cnt_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt_q <= '0;
      end else if (inc_i && !dec_i && !full_o) begin
         cnt_q <= cnt_q + CNT_W'(1);
      end else if (dec_i && !inc_i && !empty_o) begin
         cnt_q <= cnt_q - CNT_W'(1);
      end
      // inc and dec together leave the count alone
   end

   assign empty_o = (cnt_q == '0);
   // full at all ones, upstream gating stops further increments
   assign full_o  = &cnt_q;

endmodule

`default_nettype wire

// ==== merge/axi_merge_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_merge_ctrl
   import axi_merge_pkg::*;
(
   input  logic               clk_i,
   input  logic               arst_n_i,
   // raw per-port requests
   input  logic [N_PORTS-1:0] arvalid_i,
   input  logic [N_PORTS-1:0] awvalid_i,
   // manager-side handshake events
   input  logic               ar_done_i,
   input  logic               r_last_done_i,
   input  logic               aw_done_i,
   input  logic               w_last_done_i,
   input  logic               b_done_i,
   // selections
   output port_idx_t          rd_sel_o,
   output port_idx_t          rd_sel_q_o,
   output port_idx_t          wr_sel_o,
   output port_idx_t          wr_sel_q_o,
   // gating levels
   output logic               ar_allow_o,
   output logic               aw_allow_o,
   output logic               w_allow_o
);

   // highest requesting index wins, 0 when idle
   function automatic port_idx_t prio_high(input logic [N_PORTS-1:0] req);
      port_idx_t idx;
      idx = '0;
      for (int i = 0; i < N_PORTS; i++) begin
         if (req[i]) begin
            idx = port_idx_t'(i);
         end
      end
      return idx;
   endfunction

   rd_state_e rd_state_q;
   rd_state_e rd_state_d;
   port_idx_t rd_prio;
   port_idx_t wr_prio;
   logic      rd_req;
   logic      wr_req;
   logic      wr_busy_q;
   logic      wr_switch;
   logic      addr_empty;
   logic      addr_full;
   logic      resp_empty;
   logic      resp_full;

   assign rd_prio = prio_high(arvalid_i);
   assign wr_prio = prio_high(awvalid_i);

   // read selection only moves while idle
   assign rd_sel_o   = (rd_state_q == RD_IDLE) ? rd_prio : rd_sel_q_o;
   // no new address once it has been accepted
   assign ar_allow_o = (rd_state_q != RD_DATA);
   // merged arvalid as presented to the manager
   assign rd_req     = arvalid_i[rd_sel_o] & ar_allow_o;

   always_comb begin
      rd_state_d = rd_state_q;
      case (rd_state_q)
         RD_IDLE: begin
            // address may be taken in the very first cycle
            if (ar_done_i) begin
               rd_state_d = RD_DATA;
            end else if (rd_req) begin
               rd_state_d = RD_ADDR;
            end
         end
         RD_ADDR: begin
            if (ar_done_i) begin
               rd_state_d = RD_DATA;
            end
         end
         RD_DATA: begin
            rd_state_d = RD_DATA;
         end
         default: begin
            rd_state_d = RD_IDLE;
         end
      endcase
      // last beat frees the read side from any state
      if (r_last_done_i) begin
         rd_state_d = RD_IDLE;
      end
   end

   // write selection held while busy or any address is outstanding
   assign wr_sel_o  = (wr_busy_q | ~addr_empty) ? wr_sel_q_o : wr_prio;
   // other port is now the preferred one
   assign wr_switch = (wr_sel_o != wr_prio);

   assign aw_allow_o = ~(addr_full | (~addr_empty & wr_switch));
   assign w_allow_o  = ~(resp_full | (~resp_empty & wr_switch));

   // gated awvalid toward the manager
   assign wr_req = awvalid_i[wr_sel_o] & aw_allow_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_state_q <= RD_IDLE;
         rd_sel_q_o <= '0;
         wr_sel_q_o <= '0;
         wr_busy_q  <= 1'b0;
      end else begin
         rd_state_q <= rd_state_d;
         rd_sel_q_o <= rd_sel_o;
         wr_sel_q_o <= wr_sel_o;
         // a presented address keeps the flag over a response
         if (wr_req) begin
            wr_busy_q <= 1'b1;
         end else if (b_done_i) begin
            wr_busy_q <= 1'b0;
         end
      end
   end

   // addresses accepted, waiting on B
   txn_counter addr_cnt (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .inc_i   (aw_done_i),
      .dec_i   (b_done_i),
      .empty_o (addr_empty),
      .full_o  (addr_full)
   );

   // bursts fully written, waiting on B
   txn_counter resp_cnt (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .inc_i   (w_last_done_i),
      .dec_i   (b_done_i),
      .empty_o (resp_empty),
      .full_o  (resp_full)
   );

endmodule

`default_nettype wire

// ==== source/read_route.sv ====
`timescale 1ns/10ps
`default_nettype none

module read_route
   import axi_merge_pkg::*;
(
   // current and registered selection
   input  port_idx_t                   sel_i,
   input  port_idx_t                   sel_q_i,
   input  logic                        allow_i,
   // subordinate side
   input  sub_addr_req_t [N_PORTS-1:0] s_ar_i,
   input  logic [N_PORTS-1:0]          s_arvalid_i,
   output logic [N_PORTS-1:0]          s_arready_o,
   output r_beat_t [N_PORTS-1:0]       s_r_o,
   output logic [N_PORTS-1:0]          s_rvalid_o,
   input  logic [N_PORTS-1:0]          s_rready_i,
   // manager side
   output mgr_addr_req_t               m_ar_o,
   output logic                        m_arvalid_o,
   input  logic                        m_arready_i,
   input  r_beat_t                     m_r_i,
   input  logic                        m_rvalid_i,
   output logic                        m_rready_o,
   // handshake events for the control block
   output logic                        ar_done_o,
   output logic                        r_last_done_o
);

   logic ar_ready_gated;

   // AR mux, port index on top of the address
   assign m_ar_o      = to_mgr_req(sel_i, s_ar_i[sel_i]);
   assign m_arvalid_o = allow_i & s_arvalid_i[sel_i];
   // ready also blocked while data is in flight
   assign ar_ready_gated = allow_i & m_arready_i;

   always_comb begin
      for (int p = 0; p < N_PORTS; p++) begin
         s_arready_o[p] = (sel_i == port_idx_t'(p)) & ar_ready_gated;
         // R demux by registered selection
         s_rvalid_o[p]  = (sel_q_i == port_idx_t'(p)) & m_rvalid_i;
         s_r_o[p]       = (sel_q_i == port_idx_t'(p)) ? m_r_i : '0;
      end
   end

   assign m_rready_o = s_rready_i[sel_q_i];

   assign ar_done_o     = m_arvalid_o & m_arready_i;
   assign r_last_done_o = m_rvalid_i & m_rready_o & m_r_i.last;

endmodule

`default_nettype wire

// ==== source/write_route.sv ====
`timescale 1ns/10ps
`default_nettype none

module write_route
   import axi_merge_pkg::*;
(
   // current and registered selection
   input  port_idx_t                   sel_i,
   input  port_idx_t                   sel_q_i,
   input  logic                        aw_allow_i,
   input  logic                        w_allow_i,
   // subordinate AW
   input  sub_addr_req_t [N_PORTS-1:0] s_aw_i,
   input  logic [N_PORTS-1:0]          s_awvalid_i,
   output logic [N_PORTS-1:0]          s_awready_o,
   // subordinate W
   input  w_beat_t [N_PORTS-1:0]       s_w_i,
   input  logic [N_PORTS-1:0]          s_wvalid_i,
   output logic [N_PORTS-1:0]          s_wready_o,
   // subordinate B
   output b_resp_t [N_PORTS-1:0]       s_b_o,
   output logic [N_PORTS-1:0]          s_bvalid_o,
   input  logic [N_PORTS-1:0]          s_bready_i,
   // manager side
   output mgr_addr_req_t               m_aw_o,
   output logic                        m_awvalid_o,
   input  logic                        m_awready_i,
   output w_beat_t                     m_w_o,
   output logic                        m_wvalid_o,
   input  logic                        m_wready_i,
   input  b_resp_t                     m_b_i,
   input  logic                        m_bvalid_i,
   output logic                        m_bready_o,
   // handshake events for the control block
   output logic                        aw_done_o,
   output logic                        w_last_done_o,
   output logic                        b_done_o
);

   logic aw_ready_gated;
   logic w_ready_gated;

   // AW mux, port index on top of the address
   assign m_aw_o      = to_mgr_req(sel_i, s_aw_i[sel_i]);
   assign m_awvalid_o = aw_allow_i & s_awvalid_i[sel_i];
   assign aw_ready_gated = aw_allow_i & m_awready_i;

   // W follows the same selection
   // wvalid ahead of awvalid would land on the wrong port
   assign m_w_o       = s_w_i[sel_i];
   assign m_wvalid_o  = w_allow_i & s_wvalid_i[sel_i];
   assign w_ready_gated = w_allow_i & m_wready_i;

   always_comb begin
      for (int p = 0; p < N_PORTS; p++) begin
         s_awready_o[p] = (sel_i == port_idx_t'(p)) & aw_ready_gated;
         s_wready_o[p]  = (sel_i == port_idx_t'(p)) & w_ready_gated;
         // B demux by registered selection
         s_bvalid_o[p]  = (sel_q_i == port_idx_t'(p)) & m_bvalid_i;
         s_b_o[p]       = (sel_q_i == port_idx_t'(p)) ? m_b_i : '0;
      end
   end

   assign m_bready_o = s_bready_i[sel_q_i];

   assign aw_done_o     = m_awvalid_o & m_awready_i;
   // only the closing beat of a burst counts
   assign w_last_done_o = m_wvalid_o & m_wready_i & m_w_o.last;
   assign b_done_o      = m_bvalid_i & m_bready_o;

endmodule

`default_nettype wire

// ==== source/axi_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_merge
   import axi_merge_pkg::*;
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   // subordinate ports, indexed by port
   input  sub_addr_req_t [N_PORTS-1:0] s_ar_i,
   input  logic [N_PORTS-1:0]          s_arvalid_i,
   output logic [N_PORTS-1:0]          s_arready_o,
   output r_beat_t [N_PORTS-1:0]       s_r_o,
   output logic [N_PORTS-1:0]          s_rvalid_o,
   input  logic [N_PORTS-1:0]          s_rready_i,
   input  sub_addr_req_t [N_PORTS-1:0] s_aw_i,
   input  logic [N_PORTS-1:0]          s_awvalid_i,
   output logic [N_PORTS-1:0]          s_awready_o,
   input  w_beat_t [N_PORTS-1:0]       s_w_i,
   input  logic [N_PORTS-1:0]          s_wvalid_i,
   output logic [N_PORTS-1:0]          s_wready_o,
   output b_resp_t [N_PORTS-1:0]       s_b_o,
   output logic [N_PORTS-1:0]          s_bvalid_o,
   input  logic [N_PORTS-1:0]          s_bready_i,
   // manager port
   output mgr_addr_req_t               m_ar_o,
   output logic                        m_arvalid_o,
   input  logic                        m_arready_i,
   input  r_beat_t                     m_r_i,
   input  logic                        m_rvalid_i,
   output logic                        m_rready_o,
   output mgr_addr_req_t               m_aw_o,
   output logic                        m_awvalid_o,
   input  logic                        m_awready_i,
   output w_beat_t                     m_w_o,
   output logic                        m_wvalid_o,
   input  logic                        m_wready_i,
   input  b_resp_t                     m_b_i,
   input  logic                        m_bvalid_i,
   output logic                        m_bready_o
);

   // selections and gating from control
   port_idx_t rd_sel;
   port_idx_t rd_sel_q;
   port_idx_t wr_sel;
   port_idx_t wr_sel_q;
   logic      ar_allow;
   logic      aw_allow;
   logic      w_allow;
   // handshake events from the datapaths
   logic      ar_done;
   logic      r_last_done;
   logic      aw_done;
   logic      w_last_done;
   logic      b_done;

   axi_merge_ctrl ctrl_i (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .arvalid_i    (s_arvalid_i),
      .awvalid_i    (s_awvalid_i),
      .ar_done_i    (ar_done),
      .r_last_done_i(r_last_done),
      .aw_done_i    (aw_done),
      .w_last_done_i(w_last_done),
      .b_done_i     (b_done),
      .rd_sel_o     (rd_sel),
      .rd_sel_q_o   (rd_sel_q),
      .wr_sel_o     (wr_sel),
      .wr_sel_q_o   (wr_sel_q),
      .ar_allow_o   (ar_allow),
      .aw_allow_o   (aw_allow),
      .w_allow_o    (w_allow)
   );

   read_route rd_route_i (
      .sel_i        (rd_sel),
      .sel_q_i      (rd_sel_q),
      .allow_i      (ar_allow),
      .s_ar_i       (s_ar_i),
      .s_arvalid_i  (s_arvalid_i),
      .s_arready_o  (s_arready_o),
      .s_r_o        (s_r_o),
      .s_rvalid_o   (s_rvalid_o),
      .s_rready_i   (s_rready_i),
      .m_ar_o       (m_ar_o),
      .m_arvalid_o  (m_arvalid_o),
      .m_arready_i  (m_arready_i),
      .m_r_i        (m_r_i),
      .m_rvalid_i   (m_rvalid_i),
      .m_rready_o   (m_rready_o),
      .ar_done_o    (ar_done),
      .r_last_done_o(r_last_done)
   );

   write_route wr_route_i (
      .sel_i        (wr_sel),
      .sel_q_i      (wr_sel_q),
      .aw_allow_i   (aw_allow),
      .w_allow_i    (w_allow),
      .s_aw_i       (s_aw_i),
      .s_awvalid_i  (s_awvalid_i),
      .s_awready_o  (s_awready_o),
      .s_w_i        (s_w_i),
      .s_wvalid_i   (s_wvalid_i),
      .s_wready_o   (s_wready_o),
      .s_b_o        (s_b_o),
      .s_bvalid_o   (s_bvalid_o),
      .s_bready_i   (s_bready_i),
      .m_aw_o       (m_aw_o),
      .m_awvalid_o  (m_awvalid_o),
      .m_awready_i  (m_awready_i),
      .m_w_o        (m_w_o),
      .m_wvalid_o   (m_wvalid_o),
      .m_wready_i   (m_wready_i),
      .m_b_i        (m_b_i),
      .m_bvalid_i   (m_bvalid_i),
      .m_bready_o   (m_bready_o),
      .aw_done_o    (aw_done),
      .w_last_done_o(w_last_done),
      .b_done_o     (b_done)
   );

endmodule

`default_nettype wire

// ==== verif/axi_merge_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_merge_sva
   import axi_merge_pkg::*;
(
   input logic      clk_i,
   input logic      arst_n_i,
   input rd_state_e rd_state_q,
   input logic      rd_req,
   input logic      r_last_done_i,
   input port_idx_t rd_sel_o,
   input port_idx_t wr_sel_o,
   input logic      aw_done_i,
   input logic      b_done_i,
   input logic      addr_empty,
   input logic      addr_full
);

   // presented read locks the FSM and the selection until its last beat
   rd_sel_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ((rd_req || rd_state_q == RD_DATA) && !r_last_done_i) |=>
         ((rd_state_q != RD_IDLE) && (rd_sel_o == $past(rd_sel_o))))
      else $error("read selection moved outside idle");

   // writes in flight pin the write selection for the next cycle
   wr_sel_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ((aw_done_i || !addr_empty) && !b_done_i) |=> (wr_sel_o == $past(wr_sel_o)))
      else $error("write selection moved with writes outstanding");

   // counter limit reaches the manager handshake
   aw_full_block: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      addr_full |-> !aw_done_i)
      else $error("write address accepted with a full counter");

endmodule

bind axi_merge_ctrl axi_merge_sva sva_i (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .rd_state_q   (rd_state_q),
   .rd_req       (rd_req),
   .r_last_done_i(r_last_done_i),
   .rd_sel_o     (rd_sel_o),
   .wr_sel_o     (wr_sel_o),
   .aw_done_i    (aw_done_i),
   .b_done_i     (b_done_i),
   .addr_empty   (addr_empty),
   .addr_full    (addr_full)
);

`default_nettype wire

// ==== verif/axi_merge_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module axi_merge_tb
   import axi_merge_pkg::*;
();

   // trace record layout, one word per column
   localparam int REC_W      = 7;
   localparam int F_KIND     = 0;
   localparam int F_PORT     = 1;
   localparam int F_ADDR     = 2;
   localparam int F_ID       = 3;
   localparam int F_LEN      = 4;
   localparam int F_START    = 5;
   localparam int F_DATA     = 6;
   localparam int MAX_REC    = 32;
   localparam int WAIT_LIMIT = 300;
   localparam int RUN_LIMIT  = 5000;
   // port driver states
   localparam int S_IDLE = 0;
   localparam int S_AR   = 1;
   localparam int S_R    = 2;
   localparam int S_AW   = 3;
   localparam int S_W    = 4;
   localparam int S_DONE = 5;

   // burst in flight at the manager model
   typedef struct packed {
      logic            port;
      logic [ID_W-1:0] id;
      logic [LEN_W-1:0] len;
      logic [31:0]     base;
   } pend_t;

   logic                        clk_i;
   logic                        arst_n_i;
   sub_addr_req_t [N_PORTS-1:0] s_ar_i;
   logic [N_PORTS-1:0]          s_arvalid_i;
   logic [N_PORTS-1:0]          s_arready_o;
   r_beat_t [N_PORTS-1:0]       s_r_o;
   logic [N_PORTS-1:0]          s_rvalid_o;
   logic [N_PORTS-1:0]          s_rready_i;
   sub_addr_req_t [N_PORTS-1:0] s_aw_i;
   logic [N_PORTS-1:0]          s_awvalid_i;
   logic [N_PORTS-1:0]          s_awready_o;
   w_beat_t [N_PORTS-1:0]       s_w_i;
   logic [N_PORTS-1:0]          s_wvalid_i;
   logic [N_PORTS-1:0]          s_wready_o;
   b_resp_t [N_PORTS-1:0]       s_b_o;
   logic [N_PORTS-1:0]          s_bvalid_o;
   logic [N_PORTS-1:0]          s_bready_i;
   mgr_addr_req_t               m_ar_o;
   logic                        m_arvalid_o;
   logic                        m_arready_i;
   r_beat_t                     m_r_i;
   logic                        m_rvalid_i;
   logic                        m_rready_o;
   mgr_addr_req_t               m_aw_o;
   logic                        m_awvalid_o;
   logic                        m_awready_i;
   w_beat_t                     m_w_o;
   logic                        m_wvalid_o;
   logic                        m_wready_i;
   b_resp_t                     m_b_i;
   logic                        m_bvalid_i;
   logic                        m_bready_o;

   logic [31:0] trace_mem [0:REC_W*MAX_REC-1];
   logic [31:0] rng;
   int          cycle;
   int          cur [N_PORTS];
   int          st [N_PORTS];
   int          beat [N_PORTS];
   int          wait_cnt [N_PORTS];
   int          wr_out [N_PORTS];
   int          rbeat;
   int          wbeat;
   int          n_rd;
   int          n_wr;
   int          rd_done_cnt;
   int          wr_done_cnt;
   logic        ar_shown;
   pend_t       rd_q [$];
   pend_t       aw_q [$];
   pend_t       b_q [$];

   axi_merge axi_merge_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .s_ar_i     (s_ar_i),
      .s_arvalid_i(s_arvalid_i),
      .s_arready_o(s_arready_o),
      .s_r_o      (s_r_o),
      .s_rvalid_o (s_rvalid_o),
      .s_rready_i (s_rready_i),
      .s_aw_i     (s_aw_i),
      .s_awvalid_i(s_awvalid_i),
      .s_awready_o(s_awready_o),
      .s_w_i      (s_w_i),
      .s_wvalid_i (s_wvalid_i),
      .s_wready_o (s_wready_o),
      .s_b_o      (s_b_o),
      .s_bvalid_o (s_bvalid_o),
      .s_bready_i (s_bready_i),
      .m_ar_o     (m_ar_o),
      .m_arvalid_o(m_arvalid_o),
      .m_arready_i(m_arready_i),
      .m_r_i      (m_r_i),
      .m_rvalid_i (m_rvalid_i),
      .m_rready_o (m_rready_o),
      .m_aw_o     (m_aw_o),
      .m_awvalid_o(m_awvalid_o),
      .m_awready_i(m_awready_i),
      .m_w_o      (m_w_o),
      .m_wvalid_o (m_wvalid_o),
      .m_wready_i (m_wready_i),
      .m_b_i      (m_b_i),
      .m_bvalid_i (m_bvalid_i),
      .m_bready_o (m_bready_o)
   );

   always #4 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // strobe pattern walks with the beat number
   function automatic logic [STRB_W-1:0] strb_for(input int k);
      return 4'hF >> k[1:0];
   endfunction

   // next trace entry of a port after entry from, -1 when none
   function automatic int next_tx(input int p, input int from);
      for (int i = from + 1; i < MAX_REC; i++) begin
         if (trace_mem[i*REC_W+F_KIND] == 32'hff) begin
            return -1;
         end
         if (trace_mem[i*REC_W+F_PORT] == 32'(p)) begin
            return i;
         end
      end
      return -1;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check(input string name, input logic [63:0] exp_val,
                        input logic [63:0] act_val);
      if (exp_val !== act_val) begin
         $display("Mismatch %s expected %0h actual %0h", name, exp_val, act_val);
         abort_run("value check failed");
      end
   endtask

   // manager request against the trace entry of its port
   task automatic check_addr(input string name, input int p, input mgr_addr_req_t req);
      int                    idx;
      logic [MGR_ADDR_W-1:0] exp_addr;
      idx = cur[p];
      if (idx < 0) begin
         abort_run("address arrived from a port with nothing pending");
      end
      exp_addr = {1'(p), trace_mem[idx*REC_W+F_ADDR][SUB_ADDR_W-1:0]};
      check({name, " addr"}, 64'(exp_addr), 64'(req.addr));
      check({name, " id"}, 64'(trace_mem[idx*REC_W+F_ID][ID_W-1:0]), 64'(req.id));
      check({name, " len"}, 64'(trace_mem[idx*REC_W+F_LEN][LEN_W-1:0]), 64'(req.len));
      check({name, " size"}, 64'(3'd2), 64'(req.size));
      check({name, " burst"}, 64'(2'b01), 64'(req.burst));
   endtask

   // manager-side model, sampled mid-cycle
   task automatic respond();
      int         p;
      pend_t      h;
      logic [1:0] exp_v;
      if (m_arvalid_o) begin
         // next address waits for the last beat of the current read
         if (rd_q.size() != 0) begin
            abort_run("read address presented while another read was in flight");
         end
         // both requesting on first show, port 1 goes first
         if (!ar_shown && s_arvalid_i == 2'b11) begin
            check("read priority", 64'(1), 64'(m_ar_o.addr[SUB_ADDR_W]));
         end
         ar_shown = 1'b1;
         if (m_arready_i) begin
            p = int'(m_ar_o.addr[SUB_ADDR_W]);
            check_addr("read", p, m_ar_o);
            h.port = m_ar_o.addr[SUB_ADDR_W];
            h.id   = m_ar_o.id;
            h.len  = m_ar_o.len;
            h.base = 32'(m_ar_o.addr);
            rd_q.push_back(h);
            ar_shown = 1'b0;
         end
      end
      if (m_rvalid_i) begin
         h     = rd_q[0];
         exp_v = 2'b01 << h.port;
         check("read valid routing", 64'(exp_v), 64'(s_rvalid_o));
         if (m_rready_o) begin
            if (rbeat == int'(h.len)) begin
               void'(rd_q.pop_front());
               rbeat = 0;
            end else begin
               rbeat++;
            end
         end
      end
      if (m_awvalid_o) begin
         p = int'(m_aw_o.addr[SUB_ADDR_W]);
         // no switch while the other port still waits on B
         check("write switching", 64'(0), 64'(wr_out[1-p]));
         if (m_awready_i) begin
            check_addr("write", p, m_aw_o);
            h.port = 1'(p);
            h.id   = m_aw_o.id;
            h.len  = m_aw_o.len;
            h.base = trace_mem[cur[p]*REC_W+F_DATA];
            aw_q.push_back(h);
            wr_out[p]++;
         end
      end
      if (m_wvalid_o && m_wready_i) begin
         if (aw_q.size() == 0) begin
            abort_run("write data reached the manager without an address");
         end
         h = aw_q[0];
         check("write data", 64'(h.base + 32'(wbeat)), 64'(m_w_o.data));
         check("write strb", 64'(strb_for(wbeat)), 64'(m_w_o.strb));
         check("write last", 64'(wbeat == int'(h.len)), 64'(m_w_o.last));
         if (wbeat == int'(h.len)) begin
            b_q.push_back(h);
            void'(aw_q.pop_front());
            wbeat = 0;
         end else begin
            wbeat++;
         end
      end
      if (m_bvalid_i) begin
         h     = b_q[0];
         exp_v = 2'b01 << h.port;
         check("write resp routing", 64'(exp_v), 64'(s_bvalid_o));
         check("write resp", 64'({2'b00, h.id}), 64'(s_b_o[h.port]));
         if (m_bready_o) begin
            void'(b_q.pop_front());
            wr_out[h.port]--;
            wr_done_cnt++;
         end
      end
   endtask

   // subordinate port driver, one transaction at a time
   task automatic step_port(input int p);
      int          idx;
      int          len;
      logic [31:0] exp_data;
      idx = cur[p];
      len = (idx < 0) ? 0 : int'(trace_mem[idx*REC_W+F_LEN][LEN_W-1:0]);
      wait_cnt[p]++;
      case (st[p])
         S_IDLE: begin
            wait_cnt[p] = 0;
            if (idx < 0) begin
               st[p] = S_DONE;
            end else if (cycle >= int'(trace_mem[idx*REC_W+F_START])) begin
               st[p]   = (trace_mem[idx*REC_W+F_KIND] == 32'd1) ? S_AW : S_AR;
               beat[p] = 0;
            end
         end
         S_AR: begin
            if (s_arready_o[p]) begin
               st[p]       = S_R;
               wait_cnt[p] = 0;
            end
         end
         S_R: begin
            if (s_rvalid_o[p]) begin
               // data is the manager address plus the beat
               exp_data = 32'({1'(p), trace_mem[idx*REC_W+F_ADDR][SUB_ADDR_W-1:0]});
               exp_data = exp_data + 32'(beat[p]);
               check("read data", 64'(exp_data), 64'(s_r_o[p].data));
               check("read id", 64'(trace_mem[idx*REC_W+F_ID][ID_W-1:0]), 64'(s_r_o[p].id));
               check("read resp", 64'(0), 64'(s_r_o[p].resp));
               check("read last", 64'(beat[p] == len), 64'(s_r_o[p].last));
               wait_cnt[p] = 0;
               if (beat[p] == len) begin
                  rd_done_cnt++;
                  cur[p] = next_tx(p, idx);
                  st[p]  = S_IDLE;
               end else begin
                  beat[p]++;
               end
            end
         end
         S_AW: begin
            if (s_awready_o[p]) begin
               st[p]       = S_W;
               wait_cnt[p] = 0;
            end
         end
         S_W: begin
            if (s_wready_o[p]) begin
               wait_cnt[p] = 0;
               if (beat[p] == len) begin
                  cur[p] = next_tx(p, idx);
                  st[p]  = S_IDLE;
               end else begin
                  beat[p]++;
               end
            end
         end
         default: begin
            wait_cnt[p] = 0;
         end
      endcase
      if (wait_cnt[p] > WAIT_LIMIT) begin
         abort_run($sformatf("port %0d timed out waiting for a handshake", p));
      end
   endtask

   task automatic drive_all();
      int    idx;
      pend_t h;
      rng = xorshift32(rng);
      // readies high about three cycles out of four
      m_arready_i = rng[0] | rng[1];
      m_awready_i = rng[2] | rng[3];
      m_wready_i  = rng[4] | rng[5];
      m_rvalid_i  = (rd_q.size() != 0);
      m_r_i       = '0;
      if (m_rvalid_i) begin
         h            = rd_q[0];
         m_r_i.data   = h.base + 32'(rbeat);
         m_r_i.id     = h.id;
         m_r_i.last   = (rbeat == int'(h.len));
      end
      m_bvalid_i = (b_q.size() != 0);
      m_b_i      = '0;
      if (m_bvalid_i) begin
         h        = b_q[0];
         m_b_i.id = h.id;
      end
      for (int p = 0; p < N_PORTS; p++) begin
         idx            = cur[p];
         s_arvalid_i[p] = (st[p] == S_AR);
         s_awvalid_i[p] = (st[p] == S_AW);
         s_wvalid_i[p]  = (st[p] == S_W);
         s_ar_i[p]      = '0;
         s_w_i[p]       = '0;
         if (idx >= 0) begin
            s_ar_i[p].addr  = trace_mem[idx*REC_W+F_ADDR][SUB_ADDR_W-1:0];
            s_ar_i[p].id    = trace_mem[idx*REC_W+F_ID][ID_W-1:0];
            s_ar_i[p].len   = trace_mem[idx*REC_W+F_LEN][LEN_W-1:0];
            s_ar_i[p].size  = 3'd2;
            s_ar_i[p].burst = 2'b01;
            s_w_i[p].data   = trace_mem[idx*REC_W+F_DATA] + 32'(beat[p]);
            s_w_i[p].strb   = strb_for(beat[p]);
            s_w_i[p].last   = (beat[p] == int'(trace_mem[idx*REC_W+F_LEN][LEN_W-1:0]));
         end
         s_aw_i[p] = s_ar_i[p];
      end
   endtask

   function automatic logic run_finished();
      return st[0] == S_DONE && st[1] == S_DONE && rd_q.size() == 0 &&
             aw_q.size() == 0 && b_q.size() == 0;
   endfunction

   initial begin
      clk_i       = 1'b0;
      arst_n_i    = 1'b0;
      s_ar_i      = '0;
      s_arvalid_i = '0;
      s_rready_i  = '1;
      s_aw_i      = '0;
      s_awvalid_i = '0;
      s_w_i       = '0;
      s_wvalid_i  = '0;
      s_bready_i  = '1;
      m_arready_i = 1'b0;
      m_r_i       = '0;
      m_rvalid_i  = 1'b0;
      m_awready_i = 1'b0;
      m_wready_i  = 1'b0;
      m_b_i       = '0;
      m_bvalid_i  = 1'b0;
      rng         = 32'd99652;
      cycle       = 0;
      rbeat       = 0;
      wbeat       = 0;
      n_rd        = 0;
      n_wr        = 0;
      rd_done_cnt = 0;
      wr_done_cnt = 0;
      ar_shown    = 1'b0;
      $readmemh("verif/merge_trace.txt", trace_mem);
      for (int p = 0; p < N_PORTS; p++) begin
         cur[p]      = next_tx(p, -1);
         st[p]       = S_IDLE;
         beat[p]     = 0;
         wait_cnt[p] = 0;
         wr_out[p]   = 0;
      end
      // expected totals straight from the trace
      for (int i = 0; i < MAX_REC && trace_mem[i*REC_W+F_KIND] != 32'hff; i++) begin
         if (trace_mem[i*REC_W+F_KIND] == 32'd1) begin
            n_wr++;
         end else begin
            n_rd++;
         end
      end
      repeat (3) @(posedge clk_i);
      #1;
      arst_n_i = 1'b1;
      while (!run_finished()) begin
         @(negedge clk_i);
         respond();
         step_port(0);
         step_port(1);
         @(posedge clk_i);
         #1;
         drive_all();
         cycle++;
         if (cycle > RUN_LIMIT) begin
            abort_run("run did not finish within the cycle limit");
         end
      end
      check("reads completed", 64'(n_rd), 64'(rd_done_cnt));
      check("writes completed", 64'(n_wr), 64'(wr_done_cnt));
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/merge_trace.txt ====
// kind(0 read, 1 write) port addr id len start_cycle first_wdata, all hex
// a line starting with ff ends the trace
0 0 0123450 1 3 2 0
0 1 0abcde0 2 1 2 0
1 0 0001000 3 2 4 a0000000
1 0 0002000 4 0 4 b0000000
1 0 0003000 5 3 4 c0000000
1 1 0004000 6 1 6 d0000000
0 0 0200000 7 0 8 0
0 1 0300040 8 5 8 0
1 1 0005000 9 2 10 e0000000
1 0 0006000 a 1 10 f0000000
0 1 fffffff b 7 20 0
0 0 ffffff0 c 2 20 0
1 1 0007000 d 3 20 12345678
1 0 0008000 e 0 20 87654321
ff 0 0 0 0 0 0

// ==== sources.f ====
common/axi_merge_pkg.sv
merge/txn_counter.sv
merge/axi_merge_ctrl.sv
source/read_route.sv
source/write_route.sv
source/axi_merge.sv
verif/axi_merge_sva.sv
verif/axi_merge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := axi_merge_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
